// ==== tx_core.f ====
logic/tx_pkg.sv
logic/tx_channel.sv
logic/dac_common_regs.sv
logic/tx_core.sv
test/tb_tx_core.sv

// ==== Bender.yml ====
package:
  name: tx_core

sources:
  # shared package first
  - logic/tx_pkg.sv
  # transmit datapath
  - logic/tx_channel.sv
  - logic/dac_common_regs.sv
  - logic/tx_core.sv
  # directed testbench
  - target: test
    files:
      - test/tb_tx_core.sv

// ==== test/tb_tx_core.sv ====
// directed testbench that runs tx_core through bus, dma, ramp, partner, status and sync tests
`timescale 1ns/1ps

module tb_tx_core;

  localparam int clk_period = 20;
  localparam int drive_delay = 2;
  localparam int ack_limit = 8;
  localparam int num_tests = 6;
  localparam int cycles_per_test = 400;
  localparam int dut_id = 0;
  localparam logic [31:0] lfsr_seed = 32'd4;

  logic                          dac_clk;
  logic                          up_rstn;
  logic [tx_pkg::word_w-1:0]     dac_data_i0;
  logic [tx_pkg::word_w-1:0]     dac_data_q0;
  logic [tx_pkg::word_w-1:0]     dac_data_i1;
  logic [tx_pkg::word_w-1:0]     dac_data_q1;
  logic                          dac_enable_i0;
  logic                          dac_enable_q0;
  logic                          dac_enable_i1;
  logic                          dac_enable_q1;
  logic                          dac_dovf;
  logic                          dac_dunf;
  logic                          dac_sync_in;
  logic                          dac_sync_out;
  logic                          dac_rst;
  logic [4*tx_pkg::word_w-1:0]   dac_data;
  logic                          up_wreq;
  logic [tx_pkg::addr_w-1:0]     up_waddr;
  logic [tx_pkg::word_w-1:0]     up_wdata;
  logic                          up_wack;
  logic                          up_rreq;
  logic [tx_pkg::addr_w-1:0]     up_raddr;
  logic [tx_pkg::word_w-1:0]     up_rdata;
  logic                          up_rack;

  logic [tx_pkg::word_w-1:0]     dma [4];
  logic [tx_pkg::sample_w-1:0]   ramp_inc_val;
  logic [31:0]                   lfsr_state;
  string                         test_name;
  int                            sync_pulses = 0;

  tx_core #(
    .id               (dut_id),
    .datapath_disable (0)
  ) u_dut (
    .dac_clk       (dac_clk),
    .up_rstn       (up_rstn),
    .dac_data_i0   (dac_data_i0),
    .dac_data_q0   (dac_data_q0),
    .dac_data_i1   (dac_data_i1),
    .dac_data_q1   (dac_data_q1),
    .dac_enable_i0 (dac_enable_i0),
    .dac_enable_q0 (dac_enable_q0),
    .dac_enable_i1 (dac_enable_i1),
    .dac_enable_q1 (dac_enable_q1),
    .dac_dovf      (dac_dovf),
    .dac_dunf      (dac_dunf),
    .dac_sync_in   (dac_sync_in),
    .dac_sync_out  (dac_sync_out),
    .dac_rst       (dac_rst),
    .dac_data      (dac_data),
    .up_wreq       (up_wreq),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_wack       (up_wack),
    .up_rreq       (up_rreq),
    .up_raddr      (up_raddr),
    .up_rdata      (up_rdata),
    .up_rack       (up_rack)
  );

  initial dac_clk = 1'b0;
  always #(clk_period / 2) dac_clk = ~dac_clk;

  // counts cycles with sync_out high
  always @(posedge dac_clk) begin
    if (dac_sync_out) begin
      sync_pulses = sync_pulses + 1;
    end
  end

  // ************************************************************************
  // helpers

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1, "run stopped");
  endtask

  task automatic check_word(input string what, input logic [tx_pkg::word_w-1:0] expected,
                            input logic [tx_pkg::word_w-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                               test_name, what, expected, actual));
    end
  endtask

  task automatic check_sample(input string what, input logic [tx_pkg::sample_w-1:0] expected,
                              input logic [tx_pkg::sample_w-1:0] actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s %s: expected %h, actual %h",
                               test_name, what, expected, actual));
    end
  endtask

  task automatic check_bit(input string what, input logic expected, input logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("CHECK FAILED %s %s: expected %b, actual %b",
                               test_name, what, expected, actual));
    end
  endtask

  // right-shift galois lfsr with polynomial x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_random(input int nbits, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < nbits; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = {value[30:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [tx_pkg::word_w-1:0] lane_word(input int ch);
    return dac_data[ch*tx_pkg::word_w +: tx_pkg::word_w];
  endfunction

  function automatic logic [tx_pkg::sample_w-1:0] to_offset(
      input logic [tx_pkg::sample_w-1:0] s);
    return {~s[tx_pkg::sample_w-1], s[tx_pkg::sample_w-2:0]};
  endfunction

  task automatic next_cycle();
    @(posedge dac_clk);
    #drive_delay;
  endtask

  task automatic drive_dma();
    logic [31:0] w;
    for (int ch = 0; ch < 4; ch++) begin
      take_random(tx_pkg::word_w, w);
      dma[ch] = w;
    end
    dac_data_i0 = dma[0];
    dac_data_q0 = dma[1];
    dac_data_i1 = dma[2];
    dac_data_q1 = dma[3];
  endtask

  // ************************************************************************
  // processor bus

  task automatic write_reg(input logic [tx_pkg::addr_w-1:0] addr,
                           input logic [tx_pkg::word_w-1:0] data);
    int cycles;
    up_waddr = addr;
    up_wdata = data;
    up_wreq = 1'b1;
    next_cycle();
    up_wreq = 1'b0;
    cycles = 1;
    while (!up_wack && cycles < ack_limit) begin
      next_cycle();
      cycles++;
    end
    if (!up_wack) begin
      report_failure($sformatf("no write acknowledge within %0d cycles at address %h",
                               ack_limit, addr));
    end
  endtask

  task automatic bus_read(input logic [tx_pkg::addr_w-1:0] addr,
                          output logic [tx_pkg::word_w-1:0] data, output logic acked);
    int cycles;
    up_raddr = addr;
    up_rreq = 1'b1;
    next_cycle();
    up_rreq = 1'b0;
    cycles = 1;
    while (!up_rack && cycles < ack_limit) begin
      next_cycle();
      cycles++;
    end
    acked = up_rack;
    data = up_rdata;
  endtask

  task automatic read_reg(input logic [tx_pkg::addr_w-1:0] addr,
                          output logic [tx_pkg::word_w-1:0] data);
    logic acked;
    bus_read(addr, data, acked);
    if (!acked) begin
      report_failure($sformatf("no read acknowledge within %0d cycles at address %h",
                               ack_limit, addr));
    end
  endtask

  // ************************************************************************
  // tests

  task automatic reset_and_registers();
    logic [tx_pkg::word_w-1:0] rd;
    logic [31:0]               rnd;
    logic                      acked;
    test_name = "reset_regs";
    check_bit("dac_rst", 1'b1, dac_rst);
    check_bit("enable i0", 1'b0, dac_enable_i0);
    check_bit("enable q0", 1'b0, dac_enable_q0);
    check_bit("enable i1", 1'b0, dac_enable_i1);
    check_bit("enable q1", 1'b0, dac_enable_q1);
    for (int ch = 0; ch < 4; ch++) begin
      check_word($sformatf("reset lane %0d", ch), '0, lane_word(ch));
    end
    read_reg(tx_pkg::addr_id, rd);
    check_word("id", dut_id, rd);
    take_random(tx_pkg::sample_w, rnd);
    write_reg(tx_pkg::chan_addr(2, tx_pkg::reg_inc), rnd);
    read_reg(tx_pkg::chan_addr(2, tx_pkg::reg_inc), rd);
    check_word("inc readback", rnd, rd);
    write_reg(tx_pkg::chan_addr(3, tx_pkg::reg_src), tx_pkg::src_partner);
    read_reg(tx_pkg::chan_addr(3, tx_pkg::reg_src), rd);
    check_word("src readback", tx_pkg::src_partner, rd);
    write_reg(tx_pkg::chan_addr(3, tx_pkg::reg_src), tx_pkg::src_dma);
    read_reg(tx_pkg::chan_addr(3, tx_pkg::reg_src), rd);
    check_word("src restore", tx_pkg::src_dma, rd);
    // nothing decodes this address
    bus_read(14'h0050, rd, acked);
    check_bit("unmapped ack", 1'b0, acked);
  endtask

  task automatic dma_passthrough();
    logic [tx_pkg::word_w-1:0] w;
    test_name = "dma_passthrough";
    write_reg(tx_pkg::addr_rstn, 32'h1 << tx_pkg::rstn_bit);
    check_bit("dac_rst", 1'b0, dac_rst);
    check_bit("enable i0", 1'b1, dac_enable_i0);
    check_bit("enable q0", 1'b1, dac_enable_q0);
    check_bit("enable i1", 1'b1, dac_enable_i1);
    check_bit("enable q1", 1'b1, dac_enable_q1);
    repeat (8) begin
      drive_dma();
      next_cycle();
      for (int ch = 0; ch < 4; ch++) begin
        check_word($sformatf("lane %0d", ch), dma[ch], lane_word(ch));
      end
    end
    write_reg(tx_pkg::addr_ctrl, 32'h1 << tx_pkg::ctrl_fmt_bit);
    repeat (4) begin
      drive_dma();
      next_cycle();
      for (int ch = 0; ch < 4; ch++) begin
        w = lane_word(ch);
        check_sample("offset low", to_offset(dma[ch][15:0]), w[15:0]);
        check_sample("offset high", to_offset(dma[ch][31:16]), w[31:16]);
      end
    end
    write_reg(tx_pkg::addr_ctrl, 32'h0);
  endtask

  // writes sync and follows r = 0, 2 inc, 4 inc ... on channel ch
  task automatic sync_and_check_ramp(input int ch, input int n, input logic toggle_sync_in);
    logic [tx_pkg::sample_w-1:0] r;
    logic [tx_pkg::word_w-1:0]   w;
    int                          pulses_before;
    pulses_before = sync_pulses;
    write_reg(tx_pkg::addr_ctrl, 32'h1 << tx_pkg::ctrl_sync_bit);
    // two more cycles for the ramp restart and the output register
    repeat (2) next_cycle();
    r = '0;
    for (int k = 0; k < n; k++) begin
      w = lane_word(ch);
      check_sample($sformatf("ramp low %0d", k), r, w[15:0]);
      check_sample($sformatf("ramp high %0d", k), r + ramp_inc_val, w[31:16]);
      r = r + ramp_inc_val + ramp_inc_val;
      if (toggle_sync_in) begin
        dac_sync_in = ~dac_sync_in;
      end
      next_cycle();
    end
    check_word("sync pulses", 1, sync_pulses - pulses_before);
  endtask

  task automatic ramp_with_sync();
    logic [31:0] rnd;
    test_name = "ramp_sync";
    take_random(tx_pkg::sample_w, rnd);
    ramp_inc_val = rnd[15:0];
    write_reg(tx_pkg::chan_addr(1, tx_pkg::reg_inc), ramp_inc_val);
    write_reg(tx_pkg::chan_addr(1, tx_pkg::reg_src), tx_pkg::src_ramp);
    check_bit("enable q0", 1'b0, dac_enable_q0);
    check_bit("enable i0", 1'b1, dac_enable_i0);
    sync_and_check_ramp(1, 8, 1'b0);
    repeat (5) next_cycle();
    sync_and_check_ramp(1, 8, 1'b0);
  endtask

  task automatic partner_and_zero();
    test_name = "partner_zero";
    write_reg(tx_pkg::chan_addr(0, tx_pkg::reg_src), tx_pkg::src_partner);
    write_reg(tx_pkg::chan_addr(3, tx_pkg::reg_src), tx_pkg::src_partner);
    write_reg(tx_pkg::chan_addr(2, tx_pkg::reg_src), tx_pkg::src_zero);
    check_bit("enable i0", 1'b0, dac_enable_i0);
    check_bit("enable i1", 1'b0, dac_enable_i1);
    check_bit("enable q1", 1'b0, dac_enable_q1);
    repeat (6) begin
      drive_dma();
      next_cycle();
      check_word("i0 from q0", dma[1], lane_word(0));
      check_word("q1 from i1", dma[2], lane_word(3));
      check_word("i1 zero", '0, lane_word(2));
    end
  endtask

  task automatic status_bits();
    logic [tx_pkg::word_w-1:0] rd;
    test_name = "status";
    read_reg(tx_pkg::addr_status, rd);
    check_bit("unf idle", 1'b0, rd[tx_pkg::status_unf_bit]);
    check_bit("ovf idle", 1'b0, rd[tx_pkg::status_ovf_bit]);
    dac_dunf = 1'b1;
    next_cycle();
    dac_dunf = 1'b0;
    read_reg(tx_pkg::addr_status, rd);
    check_bit("unf set", 1'b1, rd[tx_pkg::status_unf_bit]);
    check_bit("ovf still clear", 1'b0, rd[tx_pkg::status_ovf_bit]);
    dac_dovf = 1'b1;
    next_cycle();
    dac_dovf = 1'b0;
    repeat (4) next_cycle();
    read_reg(tx_pkg::addr_status, rd);
    check_bit("unf sticky", 1'b1, rd[tx_pkg::status_unf_bit]);
    check_bit("ovf set", 1'b1, rd[tx_pkg::status_ovf_bit]);
    write_reg(tx_pkg::addr_status, 32'h1 << tx_pkg::status_unf_bit);
    read_reg(tx_pkg::addr_status, rd);
    check_bit("unf cleared", 1'b0, rd[tx_pkg::status_unf_bit]);
    check_bit("ovf kept", 1'b1, rd[tx_pkg::status_ovf_bit]);
    write_reg(tx_pkg::addr_status, 32'h1 << tx_pkg::status_ovf_bit);
    read_reg(tx_pkg::addr_status, rd);
    check_bit("ovf cleared", 1'b0, rd[tx_pkg::status_ovf_bit]);
  endtask

  // external sync must not disturb a master
  task automatic master_sync_source();
    test_name = "master_sync";
    sync_and_check_ramp(1, 12, 1'b1);
    dac_sync_in = 1'b0;
  endtask

  // ************************************************************************
  // run

  initial begin
    up_rstn = 1'b0;
    dac_data_i0 = '0;
    dac_data_q0 = '0;
    dac_data_i1 = '0;
    dac_data_q1 = '0;
    dac_dovf = 1'b0;
    dac_dunf = 1'b0;
    dac_sync_in = 1'b0;
    up_wreq = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
    up_rreq = 1'b0;
    up_raddr = '0;
    ramp_inc_val = '0;
    lfsr_state = lfsr_seed;
    test_name = "reset";
    repeat (5) @(posedge dac_clk);
    #drive_delay;
    up_rstn = 1'b1;
    reset_and_registers();
    dma_passthrough();
    ramp_with_sync();
    partner_and_zero();
    status_bits();
    master_sync_source();
    $display("Finished with no errors");
    $finish;
  end

  initial begin
    #(num_tests * cycles_per_test * clk_period);
    report_failure($sformatf("timeout, tests did not complete within %0d cycles",
                             num_tests * cycles_per_test));
  end

endmodule

// ==== logic/tx_core.sv ====
// top of the quad-DAC transmit path: four channels, common registers, sync select and bus merge
`timescale 1ns/1ps

module tx_core #(
  parameter int id = 0,
  parameter int datapath_disable = 0
) (
  input  logic                         dac_clk,
  input  logic                         up_rstn,
  input  logic [tx_pkg::word_w-1:0]    dac_data_i0,
  input  logic [tx_pkg::word_w-1:0]    dac_data_q0,
  input  logic [tx_pkg::word_w-1:0]    dac_data_i1,
  input  logic [tx_pkg::word_w-1:0]    dac_data_q1,
  output logic                         dac_enable_i0,
  output logic                         dac_enable_q0,
  output logic                         dac_enable_i1,
  output logic                         dac_enable_q1,
  input  logic                         dac_dovf,
  input  logic                         dac_dunf,
  input  logic                         dac_sync_in,
  output logic                         dac_sync_out,
  output logic                         dac_rst,
  output logic [4*tx_pkg::word_w-1:0]  dac_data,
  input  logic                         up_wreq,
  input  logic [tx_pkg::addr_w-1:0]    up_waddr,
  input  logic [tx_pkg::word_w-1:0]    up_wdata,
  output logic                         up_wack,
  input  logic                         up_rreq,
  input  logic [tx_pkg::addr_w-1:0]    up_raddr,
  output logic [tx_pkg::word_w-1:0]    up_rdata,
  output logic                         up_rack
);

  logic [tx_pkg::word_w-1:0] chan_in [4];
  logic [3:0]                chan_enable;
  logic                      offset_binary;
  logic                      sync_src;
  logic                      data_sync;
  logic [4:0]                wack_s;
  logic [4:0]                rack_s;
  logic [tx_pkg::word_w-1:0] rdata_s [5];

  // ************************************************************************
  // master/slave sync

  // master drives its own pulse, slaves follow the external one
  assign sync_src = (id == 0) ? dac_sync_out : dac_sync_in;

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      data_sync <= 1'b0;
    end else begin
      data_sync <= sync_src;
    end
  end

  // ************************************************************************
  // channels

  // lane order i0, q0, i1, q1
  assign chan_in[0] = dac_data_i0;
  assign chan_in[1] = dac_data_q0;
  assign chan_in[2] = dac_data_i1;
  assign chan_in[3] = dac_data_q1;

  assign dac_enable_i0 = chan_enable[0];
  assign dac_enable_q0 = chan_enable[1];
  assign dac_enable_i1 = chan_enable[2];
  assign dac_enable_q1 = chan_enable[3];

  for (genvar ch = 0; ch < 4; ch++) begin : g_chan
    // partner is the other half of the i/q pair
    tx_channel #(
      .channel_id       (ch),
      .datapath_disable (datapath_disable)
    ) u_chan (
      .dac_clk       (dac_clk),
      .up_rstn       (up_rstn),
      .dac_rst       (dac_rst),
      .data_sync     (data_sync),
      .offset_binary (offset_binary),
      .data_in       (chan_in[ch]),
      .partner_in    (chan_in[ch ^ 1]),
      .data_out      (dac_data[ch*tx_pkg::word_w +: tx_pkg::word_w]),
      .enable        (chan_enable[ch]),
      .up_wreq       (up_wreq),
      .up_waddr      (up_waddr),
      .up_wdata      (up_wdata),
      .up_wack       (wack_s[ch]),
      .up_rreq       (up_rreq),
      .up_raddr      (up_raddr),
      .up_rdata      (rdata_s[ch]),
      .up_rack       (rack_s[ch])
    );
  end

  dac_common_regs #(
    .id (id)
  ) u_common (
    .dac_clk       (dac_clk),
    .up_rstn       (up_rstn),
    .dac_dovf      (dac_dovf),
    .dac_dunf      (dac_dunf),
    .dac_rst       (dac_rst),
    .sync_out      (dac_sync_out),
    .offset_binary (offset_binary),
    .up_wreq       (up_wreq),
    .up_waddr      (up_waddr),
    .up_wdata      (up_wdata),
    .up_wack       (wack_s[4]),
    .up_rreq       (up_rreq),
    .up_raddr      (up_raddr),
    .up_rdata      (rdata_s[4]),
    .up_rack       (rack_s[4])
  );

  // ************************************************************************
  // bus reply merge

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_wack <= 1'b0;
      up_rack <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack <= |wack_s;
      up_rack <= |rack_s;
      up_rdata <= rdata_s[0] | rdata_s[1] | rdata_s[2] | rdata_s[3] | rdata_s[4];
    end
  end

endmodule

// ==== logic/dac_common_regs.sv ====
// shared control and status registers of the transmit path: datapath reset, sync, format, status
`timescale 1ns/1ps

module dac_common_regs #(
  parameter int id = 0
) (
  input  logic                         dac_clk,
  input  logic                         up_rstn,
  input  logic                         dac_dovf,
  input  logic                         dac_dunf,
  output logic                         dac_rst,
  output logic                         sync_out,
  output logic                         offset_binary,
  input  logic                         up_wreq,
  input  logic [tx_pkg::addr_w-1:0]    up_waddr,
  input  logic [tx_pkg::word_w-1:0]    up_wdata,
  output logic                         up_wack,
  input  logic                         up_rreq,
  input  logic [tx_pkg::addr_w-1:0]    up_raddr,
  output logic [tx_pkg::word_w-1:0]    up_rdata,
  output logic                         up_rack
);

  localparam logic [tx_pkg::word_w-1:0] id_value = id;

  logic                      rstn_reg;
  logic                      sync_reg;
  logic                      fmt_reg;
  logic                      unf_reg;
  logic                      ovf_reg;
  logic                      wr_rstn;
  logic                      wr_ctrl;
  logic                      wr_status;
  logic                      wr_id;
  logic                      rd_hit;
  logic [tx_pkg::word_w-1:0] rd_word;

  // ************************************************************************
  // write decode

  assign wr_rstn = up_wreq && (up_waddr == tx_pkg::addr_rstn);
  assign wr_ctrl = up_wreq && (up_waddr == tx_pkg::addr_ctrl);
  assign wr_status = up_wreq && (up_waddr == tx_pkg::addr_status);
  // id is read only, the write is acked and dropped
  assign wr_id = up_wreq && (up_waddr == tx_pkg::addr_id);

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      rstn_reg <= 1'b0;
      sync_reg <= 1'b0;
      fmt_reg <= 1'b0;
      unf_reg <= 1'b0;
      ovf_reg <= 1'b0;
      up_wack <= 1'b0;
    end else begin
      up_wack <= wr_rstn | wr_ctrl | wr_status | wr_id;
      if (wr_rstn) begin
        rstn_reg <= up_wdata[tx_pkg::rstn_bit];
      end
      // sync bit clears itself after one cycle
      sync_reg <= wr_ctrl && up_wdata[tx_pkg::ctrl_sync_bit];
      if (wr_ctrl) begin
        fmt_reg <= up_wdata[tx_pkg::ctrl_fmt_bit];
      end
      // sticky, a new event wins over a clear
      unf_reg <= dac_dunf | (unf_reg & ~(wr_status & up_wdata[tx_pkg::status_unf_bit]));
      ovf_reg <= dac_dovf | (ovf_reg & ~(wr_status & up_wdata[tx_pkg::status_ovf_bit]));
    end
  end

  assign dac_rst = ~rstn_reg;
  assign sync_out = sync_reg;
  assign offset_binary = fmt_reg;

  // ************************************************************************
  // read back

  always_comb begin
    rd_hit = 1'b1;
    rd_word = '0;
    case (up_raddr)
      tx_pkg::addr_rstn: begin
        rd_word[tx_pkg::rstn_bit] = rstn_reg;
      end
      tx_pkg::addr_ctrl: begin
        rd_word[tx_pkg::ctrl_sync_bit] = sync_reg;
        rd_word[tx_pkg::ctrl_fmt_bit] = fmt_reg;
      end
      tx_pkg::addr_status: begin
        rd_word[tx_pkg::status_unf_bit] = unf_reg;
        rd_word[tx_pkg::status_ovf_bit] = ovf_reg;
      end
      tx_pkg::addr_id: begin
        rd_word = id_value;
      end
      default: begin
        rd_hit = 1'b0;
      end
    endcase
  end

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_rack <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= up_rreq && rd_hit;
      up_rdata <= (up_rreq && rd_hit) ? rd_word : '0;
    end
  end

endmodule

// ==== logic/tx_channel.sv ====
// one transmit channel, instantiated per DAC lane by tx_core: registers, ramp, source mux, format
`timescale 1ns/1ps

module tx_channel #(
  parameter int channel_id = 0,
  parameter int datapath_disable = 0
) (
  input  logic                         dac_clk,
  input  logic                         up_rstn,
  input  logic                         dac_rst,
  input  logic                         data_sync,
  input  logic                         offset_binary,
  input  logic [tx_pkg::word_w-1:0]    data_in,
  input  logic [tx_pkg::word_w-1:0]    partner_in,
  output logic [tx_pkg::word_w-1:0]    data_out,
  output logic                         enable,
  input  logic                         up_wreq,
  input  logic [tx_pkg::addr_w-1:0]    up_waddr,
  input  logic [tx_pkg::word_w-1:0]    up_wdata,
  output logic                         up_wack,
  input  logic                         up_rreq,
  input  logic [tx_pkg::addr_w-1:0]    up_raddr,
  output logic [tx_pkg::word_w-1:0]    up_rdata,
  output logic                         up_rack
);

  localparam logic [tx_pkg::addr_w-1:0] addr_src =
    tx_pkg::chan_addr(channel_id, tx_pkg::reg_src);
  localparam logic [tx_pkg::addr_w-1:0] addr_inc =
    tx_pkg::chan_addr(channel_id, tx_pkg::reg_inc);

  logic [tx_pkg::src_w-1:0]    src_sel;
  logic [tx_pkg::sample_w-1:0] ramp_inc;
  logic                        wr_src;
  logic                        wr_inc;
  logic                        rd_hit;
  logic [tx_pkg::word_w-1:0]   rd_word;
  logic [tx_pkg::word_w-1:0]   src_word;
  logic [tx_pkg::word_w-1:0]   fmt_mask;

  // ************************************************************************
  // register window

  assign wr_src = up_wreq && (up_waddr == addr_src);
  assign wr_inc = up_wreq && (up_waddr == addr_inc);

  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      src_sel <= tx_pkg::src_dma;
      ramp_inc <= '0;
      up_wack <= 1'b0;
    end else begin
      up_wack <= wr_src | wr_inc;
      // source is fixed to dma without the datapath
      if (wr_src && (datapath_disable == 0)) begin
        src_sel <= up_wdata[tx_pkg::src_w-1:0];
      end
      if (wr_inc) begin
        ramp_inc <= up_wdata[tx_pkg::sample_w-1:0];
      end
    end
  end

  always_comb begin
    rd_hit = 1'b0;
    rd_word = '0;
    if (up_raddr == addr_src) begin
      rd_hit = 1'b1;
      rd_word[tx_pkg::src_w-1:0] = src_sel;
    end else if (up_raddr == addr_inc) begin
      rd_hit = 1'b1;
      rd_word[tx_pkg::sample_w-1:0] = ramp_inc;
    end
  end

  // one-cycle reply, zero read data otherwise
  always_ff @(posedge dac_clk) begin
    if (!up_rstn) begin
      up_rack <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= up_rreq && rd_hit;
      up_rdata <= (up_rreq && rd_hit) ? rd_word : '0;
    end
  end

  // dma words are taken only on the dma source
  assign enable = (src_sel == tx_pkg::src_dma) && !dac_rst;

  // ************************************************************************
  // sources

  if (datapath_disable == 0) begin : g_datapath
    logic [tx_pkg::sample_w-1:0] ramp_r;
    logic [tx_pkg::sample_w-1:0] ramp_r1;

    assign ramp_r1 = ramp_r + ramp_inc;

    // two samples per cycle, so step by twice the increment
    always_ff @(posedge dac_clk) begin
      if (!up_rstn) begin
        ramp_r <= '0;
      end else if (data_sync) begin
        ramp_r <= '0;
      end else begin
        ramp_r <= ramp_r + {ramp_inc[tx_pkg::sample_w-2:0], 1'b0};
      end
    end

    always_comb begin
      case (src_sel)
        tx_pkg::src_dma:     src_word = data_in;
        tx_pkg::src_ramp:    src_word = {ramp_r1, ramp_r};
        tx_pkg::src_partner: src_word = partner_in;
        default:             src_word = '0;
      endcase
    end
  end else begin : g_bypass
    assign src_word = data_in;
  end

  // ************************************************************************
  // output format

  // offset binary flips the msb of each sample
  assign fmt_mask = {offset_binary, {(tx_pkg::sample_w-1){1'b0}},
                     offset_binary, {(tx_pkg::sample_w-1){1'b0}}};

  always_ff @(posedge dac_clk) begin
    if (dac_rst) begin
      data_out <= '0;
    end else begin
      data_out <= src_word ^ fmt_mask;
    end
  end

endmodule

// ==== logic/tx_pkg.sv ====
// shared widths, register map and source codes of the quad-DAC transmit path, used by scoped name
package tx_pkg;

  // ************************************************************************
  // datapath widths

  localparam int sample_w = 16;
  localparam int word_w = 2 * sample_w;
  localparam int addr_w = 14;

  // ************************************************************************
  // common block registers

  localparam logic [addr_w-1:0] common_base = 14'h0010;
  localparam logic [addr_w-1:0] addr_rstn = common_base + 14'h0000;
  localparam logic [addr_w-1:0] addr_ctrl = common_base + 14'h0001;
  localparam logic [addr_w-1:0] addr_status = common_base + 14'h0002;
  localparam logic [addr_w-1:0] addr_id = common_base + 14'h0003;

  // bit positions
  localparam int rstn_bit = 0;
  localparam int ctrl_sync_bit = 0;
  localparam int ctrl_fmt_bit = 4;
  localparam int status_unf_bit = 0;
  localparam int status_ovf_bit = 1;

  // ************************************************************************
  // channel register windows

  localparam logic [addr_w-1:0] chan_base = 14'h0100;
  localparam logic [addr_w-1:0] chan_stride = 14'h0010;
  localparam logic [addr_w-1:0] reg_src = 14'h0000;
  localparam logic [addr_w-1:0] reg_inc = 14'h0001;

  // word address of one register in channel ch
  function automatic logic [addr_w-1:0] chan_addr(input int unsigned ch,
                                                  input logic [addr_w-1:0] offs);
    return chan_base + chan_stride * addr_w'(ch) + offs;
  endfunction

  // source select codes
  localparam int src_w = 2;
  localparam logic [src_w-1:0] src_dma = 2'd0;
  localparam logic [src_w-1:0] src_ramp = 2'd1;
  localparam logic [src_w-1:0] src_partner = 2'd2;
  localparam logic [src_w-1:0] src_zero = 2'd3;

endpackage
